/* build.f */
+incdir+include
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/control_unit.sv
hw/hazard_unit.sv
hw/datapath.sv
hw/cpu_top.sv
verif/tb_cpu.sv

/* include/tb_isa_model.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic word_t encode_r(input func_e func, input reg_addr_t rs,
                                   input reg_addr_t rt, input reg_addr_t rd);
    return {OP_RTYPE, rs, rt, rd, func};
endfunction

function automatic word_t encode_i(input opcode_e op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t encode_j(input opcode_e op, input logic [11:0] target);
    return {op, target};
endfunction

function automatic reg_addr_t random_reg();
    word_t v;
    v = take_bits(2);
    return v[1:0];
endfunction

function automatic logic [7:0] random_byte();
    word_t v;
    v = take_bits(8);
    return v[7:0];
endfunction

// forward-only control flow, register jumps get their target from LHI and ORI
task automatic build_program();
    int        pc;
    int        kind;
    int        target;
    reg_addr_t r;
    word_t     bits;
    opcode_e   op;
    pc = 0;
    while (pc < PROG_LEN) begin
        bits = take_bits(4);
        kind = int'(bits);
        case (kind)
            5: prog[pc] = encode_i(OP_ADI, random_reg(), random_reg(), random_byte());
            6: prog[pc] = encode_i(OP_ORI, random_reg(), random_reg(), random_byte());
            7: prog[pc] = encode_i(OP_LHI, random_reg(), random_reg(), random_byte());
            8: prog[pc] = encode_i(OP_LWD, random_reg(), random_reg(), random_byte());
            9: prog[pc] = encode_i(OP_SWD, random_reg(), random_reg(), random_byte());
            10: prog[pc] = encode_r(FN_WWD, random_reg(), 2'd0, 2'd0);
            11: begin
                bits = take_bits(2);
                op = opcode_e'({2'b00, bits[1:0]});
                bits = take_bits(6);
                target = pc + 1 + int'(bits) % (PROG_LEN - pc);
                prog[pc] = encode_i(op, random_reg(), random_reg(), 8'(target - pc - 1));
            end
            12: begin
                bits = take_bits(1);
                op = bits[0] ? OP_JAL : OP_JMP;
                bits = take_bits(6);
                target = pc + 1 + int'(bits) % (PROG_LEN - pc);
                prog[pc] = encode_j(op, 12'(target));
            end
            13: begin
                if (pc <= PROG_LEN - 3) begin
                    r = random_reg();
                    bits = take_bits(6);
                    target = pc + 3 + int'(bits) % (PROG_LEN - pc - 2);
                    prog[pc] = encode_i(OP_LHI, 2'd0, r, 8'h00);
                    prog[pc + 1] = encode_i(OP_ORI, r, r, 8'(target));
                    bits = take_bits(1);
                    prog[pc + 2] = encode_r(bits[0] ? FN_JRL : FN_JPR, r, 2'd0, 2'd0);
                    pc = pc + 2;
                end else begin
                    prog[pc] = encode_r(FN_WWD, random_reg(), 2'd0, 2'd0);
                end
            end
            default: begin
                bits = take_bits(3);
                prog[pc] = encode_r(func_e'({3'b000, bits[2:0]}), random_reg(),
                                    random_reg(), random_reg());
            end
        endcase
        pc = pc + 1;
    end
    for (int i = PROG_LEN; i < 256; i++) begin
        prog[i] = encode_r(FN_HLT, 2'd0, 2'd0, 2'd0);
    end
endtask

// sequential reference execution of prog over a copy of the seeded data memory
task automatic run_model();
    word_t       regs [4];
    word_t       pc;
    word_t       cur;
    word_t       instr;
    word_t       imm;
    word_t       addr;
    word_t       target;
    logic [3:0]  op;
    logic [5:0]  fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic        done;
    for (int i = 0; i < 4; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        model_dmem[i] = dmem_seed[i];
    end
    pc = '0;
    done = 1'b0;
    model_count = 0;
    model_wwd_count = 0;
    while (!done && model_count < 256) begin
        cur = pc;
        instr = prog[cur[7:0]];
        op = instr[15:12];
        fn = instr[5:0];
        rs = instr[11:10];
        rt = instr[9:8];
        rd = instr[7:6];
        imm = {{8{instr[7]}}, instr[7:0]};
        model_is_wwd[model_count] = 1'b0;
        model_count = model_count + 1;
        pc = cur + 16'd1;
        case (op)
            OP_BNE: if (regs[rs] != regs[rt]) pc = pc + imm;
            OP_BEQ: if (regs[rs] == regs[rt]) pc = pc + imm;
            OP_BGZ: if ($signed(regs[rs]) > 0) pc = pc + imm;
            OP_BLZ: if (regs[rs][15]) pc = pc + imm;
            OP_ADI: regs[rt] = regs[rs] + imm;
            OP_ORI: regs[rt] = regs[rs] | {8'h00, instr[7:0]};
            OP_LHI: regs[rt] = {instr[7:0], 8'h00};
            OP_LWD: begin
                addr = regs[rs] + imm;
                regs[rt] = model_dmem[addr[5:0]];
            end
            OP_SWD: begin
                addr = regs[rs] + imm;
                model_dmem[addr[5:0]] = regs[rt];
            end
            OP_JMP: pc = {cur[15:12], instr[11:0]};
            OP_JAL: begin
                regs[2] = cur + 16'd1;
                pc = {cur[15:12], instr[11:0]};
            end
            OP_RTYPE: begin
                case (fn)
                    FN_ADD: regs[rd] = regs[rs] + regs[rt];
                    FN_SUB: regs[rd] = regs[rs] - regs[rt];
                    FN_AND: regs[rd] = regs[rs] & regs[rt];
                    FN_ORR: regs[rd] = regs[rs] | regs[rt];
                    FN_NOT: regs[rd] = ~regs[rs];
                    FN_TCP: regs[rd] = 16'd0 - regs[rs];
                    FN_SHL: regs[rd] = regs[rs] << 1;
                    FN_SHR: regs[rd] = $signed(regs[rs]) >>> 1;
                    FN_WWD: begin
                        model_is_wwd[model_count - 1] = 1'b1;
                        model_wwd[model_wwd_count] = regs[rs];
                        model_wwd_count = model_wwd_count + 1;
                    end
                    FN_JPR: pc = regs[rs];
                    FN_JRL: begin
                        target = regs[rs];
                        regs[2] = cur + 16'd1;
                        pc = target;
                    end
                    FN_HLT: done = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end
endtask

`endif

/* verif/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_PROGRAMS    = 20;
    localparam int PROG_LEN        = 40;
    localparam int HALT_HOLD       = 20;
    // worst case per program plus reset, interrupt and halt-hold windows
    localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * (PROG_LEN + 1) * 4
                                   + NUM_PROGRAMS * 48 + 100;

    logic  Clk;
    logic  reset;
    logic  instr_read;
    word_t instr_addr;
    word_t instr_rdata;
    logic  data_read;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    word_t num_inst;
    word_t output_port;
    logic  halted;

    logic [31:0] lfsr_state = 32'h0000_546b;

    word_t prog [256];
    word_t imem [256];
    word_t dmem [64];
    word_t dmem_seed [64];
    word_t model_dmem [64];
    logic  model_is_wwd [256];
    word_t model_wwd [256];
    int    model_count;
    int    model_wwd_count;
    word_t captured [256];
    int    captured_count;
    logic  capture_en;
    word_t last_num_inst;
    int    capture_index;
    int    error_count;
    int    check_count;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic word_t take_bits(input int n);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[14:0], fb};
        end
        return value;
    endfunction

    `include "tb_isa_model.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .Clk         (Clk),
        .reset       (reset),
        .instr_read  (instr_read),
        .instr_addr  (instr_addr),
        .instr_rdata (instr_rdata),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .num_inst    (num_inst),
        .output_port (output_port),
        .halted      (halted)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // combinational memories
    assign instr_rdata = imem[instr_addr[7:0]];
    // data is returned only while the read strobe is high
    assign data_rdata  = data_read ? dmem[data_addr[5:0]] : '0;

    always @(posedge Clk) begin
        if (data_write) begin
            dmem[data_addr[5:0]] <= data_wdata;
        end
    end

    // record output_port after each retirement that the model says is a WWD
    always @(negedge Clk) begin
        if (capture_en && num_inst != last_num_inst) begin
            capture_index = int'(num_inst) - 1;
            if (capture_index < model_count && model_is_wwd[capture_index]
                && captured_count < 256) begin
                captured[captured_count] = output_port;
                captured_count = captured_count + 1;
            end
        end
        last_num_inst = num_inst;
    end

    task automatic compare(input string name, input word_t expected, input word_t actual);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic seed_data();
        for (int i = 0; i < 64; i++) begin
            dmem_seed[i] = take_bits(16);
        end
    endtask

    // reset for four cycles, memories reloaded while the core is held
    task automatic start_program(input int p);
        @(posedge Clk);
        reset <= 1'b1;
        capture_en = 1'b0;
        repeat (2) @(posedge Clk);
        for (int i = 0; i < 256; i++) begin
            imem[i] <= prog[i];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= dmem_seed[i];
        end
        @(posedge Clk);
        @(negedge Clk);
        compare($sformatf("prog %0d reset num_inst", p), 16'd0, num_inst);
        compare($sformatf("prog %0d reset output_port", p), 16'd0, output_port);
        compare($sformatf("prog %0d reset halted", p), 16'd0, halted);
        compare($sformatf("prog %0d reset data_read", p), 16'd0, data_read);
        compare($sformatf("prog %0d reset data_write", p), 16'd0, data_write);
        @(posedge Clk);
        reset <= 1'b0;
        captured_count = 0;
        capture_en = 1'b1;
        @(negedge Clk);
        compare($sformatf("prog %0d first instr_read", p), 16'd1, instr_read);
        compare($sformatf("prog %0d first instr_addr", p), 16'd0, instr_addr);
    endtask

    // rerun the loaded image briefly so the next reset lands mid-program
    task automatic interrupt_run();
        @(posedge Clk);
        reset <= 1'b1;
        capture_en = 1'b0;
        repeat (4) @(posedge Clk);
        reset <= 1'b0;
        repeat (12) @(posedge Clk);
    endtask

    task automatic check_halt(input int p);
        word_t final_count;
        final_count = num_inst;
        repeat (HALT_HOLD) begin
            @(negedge Clk);
            compare($sformatf("prog %0d halt instr_read", p), 16'd0, instr_read);
            compare($sformatf("prog %0d halt data_write", p), 16'd0, data_write);
            compare($sformatf("prog %0d halt num_inst", p), final_count, num_inst);
        end
    endtask

    task automatic check_results(input int p);
        compare($sformatf("prog %0d num_inst", p), word_t'(model_count), num_inst);
        compare($sformatf("prog %0d wwd count", p), word_t'(model_wwd_count),
                word_t'(captured_count));
        for (int i = 0; i < model_wwd_count && i < captured_count; i++) begin
            compare($sformatf("prog %0d wwd %0d", p, i), model_wwd[i], captured[i]);
        end
        // only WWD may move the output port
        compare($sformatf("prog %0d final output_port", p),
                (model_wwd_count > 0) ? model_wwd[model_wwd_count - 1] : 16'd0,
                output_port);
        for (int i = 0; i < 64; i++) begin
            compare($sformatf("prog %0d dmem[%0d]", p, i), model_dmem[i], dmem[i]);
        end
    endtask

    initial begin
        int p;
        reset = 1'b1;
        capture_en = 1'b0;
        captured_count = 0;
        last_num_inst = '0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = encode_r(FN_HLT, 2'd0, 2'd0, 2'd0);
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = word_t'(i);
        end
        for (p = 0; p < NUM_PROGRAMS; p++) begin
            if (p % 4 == 3) begin
                interrupt_run();
            end
            build_program();
            seed_data();
            run_model();
            start_program(p);
            while (!halted) begin
                @(negedge Clk);
            end
            check_halt(p);
            check_results(p);
        end
        $display("programs %0d, checks %0d, errors %0d", NUM_PROGRAMS, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the core never halted within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC
) (
    input  wire                 Clk,
    input  wire                 reset,
    output logic                instr_read,
    output cpu_pkg::word_t      instr_addr,
    input  wire cpu_pkg::word_t instr_rdata,
    output logic                data_read,
    output logic                data_write,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_wdata,
    input  wire cpu_pkg::word_t data_rdata,
    output cpu_pkg::word_t      num_inst,
    output cpu_pkg::word_t      output_port,
    output logic                halted
);
    import cpu_pkg::*;

    word_t decode_instr;
    ctrl_t ctrl;

    // decode controls return to the datapath in the same cycle
    control_unit u_control_unit (
        .instr (decode_instr),
        .ctrl  (ctrl)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .Clk          (Clk),
        .reset        (reset),
        .instr_read   (instr_read),
        .instr_addr   (instr_addr),
        .instr_rdata  (instr_rdata),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .num_inst     (num_inst),
        .output_port  (output_port),
        .halted       (halted),
        .decode_instr (decode_instr),
        .ctrl         (ctrl)
    );

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC
) (
    input  wire                 Clk,
    input  wire                 reset,
    output logic                instr_read,
    output cpu_pkg::word_t      instr_addr,
    input  wire cpu_pkg::word_t instr_rdata,
    output logic                data_read,
    output logic                data_write,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_wdata,
    input  wire cpu_pkg::word_t data_rdata,
    output cpu_pkg::word_t      num_inst,
    output cpu_pkg::word_t      output_port,
    output logic                halted,
    output cpu_pkg::word_t      decode_instr,
    input  wire cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    word_t     pc;
    word_t     next_pc;
    word_t     pred_pc;
    logic      halt_pending;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    opcode_e   id_opcode;
    func_e     id_func;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    word_t     rs_rdata;
    word_t     rt_rdata;
    word_t     id_rs_data;
    word_t     id_rt_data;
    word_t     id_imm;
    logic      id_use_rs;
    logic      id_use_rt;
    logic      id_jump;
    logic      id_halt;
    logic      stall;

    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     ex_result;
    logic      ex_link;
    logic      bcond;
    logic      ex_mispredict;
    logic      ex_jump_r;
    logic      ex_redirect;
    word_t     wb_data;

    assign instr_read = !halted;
    assign instr_addr = pc;

    // opcodes 0 to 3 are branches and are predicted taken
    assign pred_pc = (instr_rdata[15:14] == 2'b00)
                   ? pc + 16'd1 + {{8{instr_rdata[7]}}, instr_rdata[7:0]}
                   : pc + 16'd1;

    always_comb begin
        if (stall || halt_pending) begin
            next_pc = pc;
        end else if (ex_jump_r) begin
            next_pc = ex_rs_data;
        end else if (ex_mispredict) begin
            next_pc = id_ex.pc + 16'd1;
        end else if (id_jump) begin
            next_pc = {if_id.pc[15:12], if_id.instr[11:0]};
        end else if (id_halt) begin
            next_pc = pc;
        end else begin
            next_pc = pred_pc;
        end
    end

    assign decode_instr = if_id.instr;
    assign id_opcode    = opcode_e'(if_id.instr[15:12]);
    assign id_func      = func_e'(if_id.instr[5:0]);
    assign id_rs        = if_id.instr[11:10];
    assign id_rt        = if_id.instr[9:8];

    // JAL and JRL link into register 2
    assign id_rd = ((ctrl.ex.is_jump_i || ctrl.ex.is_jump_r) && ctrl.wb.reg_write) ? 2'd2
                 : ctrl.reg_dst ? if_id.instr[7:6] : id_rt;

    assign id_imm = (id_opcode == OP_ORI) ? {8'h00, if_id.instr[7:0]}
                  : {{8{if_id.instr[7]}}, if_id.instr[7:0]};

    assign id_halt = !if_id.bubble && id_opcode == OP_RTYPE && id_func == FN_HLT;
    assign id_jump = !if_id.bubble && ctrl.ex.is_jump_i;

    assign id_use_rs = !if_id.bubble && !id_halt
                    && !(id_opcode inside {OP_LHI, OP_JMP, OP_JAL});
    assign id_use_rt = !if_id.bubble
                    && (id_opcode inside {OP_BNE, OP_BEQ, OP_SWD}
                        || (id_opcode == OP_RTYPE
                            && id_func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR}));

    // bypass the register being written back this cycle
    assign id_rs_data = (mem_wb.wb.reg_write && mem_wb.rd == id_rs) ? wb_data : rs_rdata;
    assign id_rt_data = (mem_wb.wb.reg_write && mem_wb.rd == id_rt) ? wb_data : rt_rdata;

    register_file u_register_file (
        .Clk     (Clk),
        .reset   (reset),
        .rs_addr (id_rs),
        .rt_addr (id_rt),
        .wr_addr (mem_wb.rd),
        .wr_data (wb_data),
        .wr_en   (mem_wb.wb.reg_write),
        .rs_data (rs_rdata),
        .rt_data (rt_rdata)
    );

    hazard_unit u_hazard_unit (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_use_rs     (id_use_rs),
        .id_use_rt     (id_use_rt),
        .ex_rs         (id_ex.rs),
        .ex_rt         (id_ex.rt),
        .ex_rd         (id_ex.rd),
        .ex_mem_read   (id_ex.mem.mem_read),
        .mem_rd        (ex_mem.rd),
        .wb_rd         (mem_wb.rd),
        .mem_reg_write (ex_mem.wb.reg_write),
        .wb_reg_write  (mem_wb.wb.reg_write),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall)
    );

    function automatic word_t forward(input fwd_sel_e sel, input word_t reg_value);
        case (sel)
            FWD_MEM: return ex_mem.alu_out;
            FWD_WB:  return wb_data;
            default: return reg_value;
        endcase
    endfunction

    always_comb begin
        ex_rs_data = forward(fwd_a, id_ex.rs_data);
        ex_rt_data = forward(fwd_b, id_ex.rt_data);
    end

    // link value is pc+1 computed by the ALU
    assign ex_link = (id_ex.ex.is_jump_i || id_ex.ex.is_jump_r) && id_ex.wb.reg_write;
    assign alu_a   = ex_link ? id_ex.pc : ex_rs_data;

    always_comb begin
        if (ex_link) begin
            alu_b = 16'd1;
        end else if (id_ex.ex.alu_src) begin
            alu_b = id_ex.imm;
        end else if (id_ex.wb.wwd || id_ex.opcode inside {OP_BGZ, OP_BLZ}) begin
            alu_b = 16'd0;
        end else begin
            alu_b = ex_rt_data;
        end
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .opcode (id_ex.opcode),
        .func   (id_ex.func),
        .is_alu (id_ex.ex.is_alu),
        .result (alu_result)
    );

    always_comb begin
        case (id_ex.opcode)
            OP_BNE:  bcond = alu_result != 16'd0;
            OP_BEQ:  bcond = alu_result == 16'd0;
            OP_BGZ:  bcond = !alu_result[15] && alu_result != 16'd0;
            default: bcond = alu_result[15];
        endcase
    end

    assign ex_mispredict = !id_ex.bubble && id_ex.ex.is_branch && !bcond;
    assign ex_jump_r     = !id_ex.bubble && id_ex.ex.is_jump_r;
    assign ex_redirect   = ex_mispredict || ex_jump_r;
    assign ex_result     = (id_ex.opcode == OP_LHI) ? {id_ex.imm[7:0], 8'h00} : alu_result;

    assign data_read  = ex_mem.mem.mem_read;
    assign data_write = ex_mem.mem.mem_write;
    assign data_addr  = ex_mem.alu_out;
    assign data_wdata = ex_mem.store_data;

    assign wb_data = mem_wb.wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc           <= RESET_PC;
            halt_pending <= 1'b0;
            if_id.bubble <= 1'b1;
        end else begin
            pc <= next_pc;
            // nothing younger than a committed HLT enters decode
            if (id_halt && !ex_redirect) begin
                halt_pending <= 1'b1;
            end
            if (!stall) begin
                if (ex_redirect || id_jump || id_halt || halt_pending) begin
                    if_id.bubble <= 1'b1;
                end else begin
                    if_id.instr  <= instr_rdata;
                    if_id.pc     <= pc;
                    if_id.bubble <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset || stall || ex_redirect || if_id.bubble) begin
            id_ex.ex     <= '0;
            id_ex.mem    <= '0;
            id_ex.wb     <= '0;
            id_ex.bubble <= 1'b1;
            id_ex.halt   <= 1'b0;
        end else begin
            id_ex.ex      <= ctrl.ex;
            id_ex.mem     <= ctrl.mem;
            id_ex.wb      <= ctrl.wb;
            id_ex.pc      <= if_id.pc;
            id_ex.rs_data <= id_rs_data;
            id_ex.rt_data <= id_rt_data;
            id_ex.imm     <= id_imm;
            id_ex.rs      <= id_rs;
            id_ex.rt      <= id_rt;
            id_ex.rd      <= id_rd;
            id_ex.opcode  <= id_opcode;
            id_ex.func    <= id_func;
            id_ex.bubble  <= 1'b0;
            id_ex.halt    <= id_halt;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            ex_mem.mem    <= '0;
            ex_mem.wb     <= '0;
            ex_mem.bubble <= 1'b1;
            ex_mem.halt   <= 1'b0;
            mem_wb.wb     <= '0;
            mem_wb.bubble <= 1'b1;
            mem_wb.halt   <= 1'b0;
        end else begin
            ex_mem.mem        <= id_ex.mem;
            ex_mem.wb         <= id_ex.wb;
            ex_mem.alu_out    <= ex_result;
            ex_mem.store_data <= ex_rt_data;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.bubble     <= id_ex.bubble;
            ex_mem.halt       <= id_ex.halt;
            mem_wb.wb         <= ex_mem.wb;
            mem_wb.alu_out    <= ex_mem.alu_out;
            mem_wb.read_data  <= data_rdata;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.bubble     <= ex_mem.bubble;
            mem_wb.halt       <= ex_mem.halt;
        end
    end

    // retirement
    always_ff @(posedge Clk) begin
        if (reset) begin
            num_inst    <= '0;
            output_port <= '0;
            halted      <= 1'b0;
        end else if (!mem_wb.bubble) begin
            num_inst <= num_inst + 16'd1;
            if (mem_wb.wb.wwd) begin
                output_port <= mem_wb.alu_out;
            end
            if (mem_wb.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire cpu_pkg::reg_addr_t id_rs,
    input  wire cpu_pkg::reg_addr_t id_rt,
    input  wire                     id_use_rs,
    input  wire                     id_use_rt,
    input  wire cpu_pkg::reg_addr_t ex_rs,
    input  wire cpu_pkg::reg_addr_t ex_rt,
    input  wire cpu_pkg::reg_addr_t ex_rd,
    input  wire                     ex_mem_read,
    input  wire cpu_pkg::reg_addr_t mem_rd,
    input  wire cpu_pkg::reg_addr_t wb_rd,
    input  wire                     mem_reg_write,
    input  wire                     wb_reg_write,
    output cpu_pkg::fwd_sel_e       fwd_a,
    output cpu_pkg::fwd_sel_e       fwd_b,
    output logic                    stall
);
    import cpu_pkg::*;

    // the newer result in memory wins over write-back
    function automatic fwd_sel_e select(input reg_addr_t src);
        if (mem_reg_write && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_reg_write && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = select(ex_rs);
        fwd_b = select(ex_rt);
    end

    // load data only exists after memory, so a dependent decode waits a cycle
    assign stall = ex_mem_read
                && ((id_use_rs && id_rs == ex_rd) || (id_use_rt && id_rt == ex_rd));

endmodule

`default_nettype wire

/* hw/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::ctrl_t      ctrl
);
    import cpu_pkg::*;

    opcode_e opcode;
    func_e   func;

    assign opcode = opcode_e'(instr[15:12]);
    assign func   = func_e'(instr[5:0]);

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                ctrl.ex.is_branch = 1'b1;
            end
            OP_ADI, OP_ORI, OP_LHI: begin
                ctrl.ex.alu_src   = 1'b1;
                ctrl.wb.reg_write = 1'b1;
            end
            OP_LWD: begin
                ctrl.ex.alu_src    = 1'b1;
                ctrl.mem.mem_read  = 1'b1;
                ctrl.wb.mem_to_reg = 1'b1;
                ctrl.wb.reg_write  = 1'b1;
            end
            OP_SWD: begin
                ctrl.ex.alu_src    = 1'b1;
                ctrl.mem.mem_write = 1'b1;
            end
            OP_JMP: begin
                ctrl.ex.is_jump_i = 1'b1;
            end
            OP_JAL: begin
                ctrl.ex.is_jump_i = 1'b1;
                ctrl.wb.reg_write = 1'b1;
            end
            OP_RTYPE: begin
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        ctrl.reg_dst      = 1'b1;
                        ctrl.ex.is_alu    = 1'b1;
                        ctrl.wb.reg_write = 1'b1;
                    end
                    FN_WWD: ctrl.wb.wwd = 1'b1;
                    FN_JPR: ctrl.ex.is_jump_r = 1'b1;
                    FN_JRL: begin
                        ctrl.ex.is_jump_r = 1'b1;
                        ctrl.wb.reg_write = 1'b1;
                    end
                    // HLT is recognised in the datapath
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire cpu_pkg::opcode_e opcode,
    input  wire cpu_pkg::func_e   func,
    input  wire                   is_alu,
    output cpu_pkg::word_t        result
);
    import cpu_pkg::*;

    alu_op_e op;

    always_comb begin
        if (is_alu) begin
            case (func)
                FN_SUB:  op = ALU_SUB;
                FN_AND:  op = ALU_AND;
                FN_ORR:  op = ALU_ORR;
                FN_NOT:  op = ALU_NOT;
                FN_TCP:  op = ALU_TCP;
                FN_SHL:  op = ALU_SHL;
                FN_SHR:  op = ALU_SHR;
                default: op = ALU_ADD;
            endcase
        end else begin
            // branches compare by subtraction, addresses and links add
            case (opcode)
                OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: op = ALU_SUB;
                OP_ORI:  op = ALU_ORR;
                default: op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            ALU_NOT: result = ~a;
            ALU_TCP: result = ~a + 16'd1;
            ALU_SHL: result = {a[14:0], 1'b0};
            // arithmetic shift
            ALU_SHR: result = {a[15], a[15:1]};
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                     Clk,
    input  wire                     reset,
    input  wire cpu_pkg::reg_addr_t rs_addr,
    input  wire cpu_pkg::reg_addr_t rt_addr,
    input  wire cpu_pkg::reg_addr_t wr_addr,
    input  wire cpu_pkg::word_t     wr_data,
    input  wire                     wr_en,
    output cpu_pkg::word_t          rs_data,
    output cpu_pkg::word_t          rt_data
);
    import cpu_pkg::*;

    word_t regs [4];

    // old value on a same-cycle write
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_addr_t;

    localparam word_t RESET_PC = 16'h0000;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // controls grouped by the stage that consumes them
    typedef struct packed {
        logic is_jump_i;
        logic is_jump_r;
        logic is_alu;
        logic alu_src;
        logic is_branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
        logic wwd;
    } wb_ctrl_t;

    typedef struct packed {
        logic      reg_dst;
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  bubble;
    } if_id_t;

    typedef struct packed {
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        word_t     pc;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        opcode_e   opcode;
        func_e     func;
        logic      bubble;
        logic      halt;
    } id_ex_t;

    typedef struct packed {
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        word_t     alu_out;
        word_t     store_data;
        reg_addr_t rd;
        logic      bubble;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        wb_ctrl_t  wb;
        word_t     alu_out;
        word_t     read_data;
        reg_addr_t rd;
        logic      bubble;
        logic      halt;
    } mem_wb_t;

endpackage

`default_nettype wire
